/* lsu_pkg.sv */
// Load/store subsystem shared definitions
// Data and strobe widths of the memory bus and the 2-bit access-size codes
`default_nettype none

package lsu_pkg;

    // Top bit index of a data word
    localparam int XL = 63;

    // Top bit of the memory data bus
    localparam int MEM_DATA_R = 63;

    // Top bit of the byte strobe, one bit per byte lane
    localparam int MEM_STRB_R = 7;

    // Width of an access-size code
    localparam int SIZE_W = 2;

    // Access-size codes as carried on op_size
    localparam logic [SIZE_W-1:0] SIZE_BYTE   = 2'd0;  // 8 bits
    localparam logic [SIZE_W-1:0] SIZE_HALF   = 2'd1;  // 16 bits
    localparam logic [SIZE_W-1:0] SIZE_WORD   = 2'd2;  // 32 bits
    localparam logic [SIZE_W-1:0] SIZE_DOUBLE = 2'd3;  // 64 bits

endpackage

`default_nettype wire

/* mem_op_buffer.sv */
// Memory operation buffer
// Takes one load or store over a valid/ready handshake, holds it while the
// access stage runs, then holds the result until the consumer takes it
`timescale 1ns/1ps
`default_nettype none

module mem_op_buffer #(
    parameter int MEM_ADDR_R = 11
) (
    input  logic                        g_clk,
    input  logic                        g_resetn,

    input  logic                        op_valid,
    output logic                        op_ready,
    input  logic [MEM_ADDR_R:0]         op_addr,
    input  logic [lsu_pkg::XL:0]        op_wdata,
    input  logic                        op_load,
    input  logic                        op_store,
    input  logic [lsu_pkg::SIZE_W-1:0]  op_size,
    input  logic                        op_sext,

    output logic                        res_valid,
    input  logic                        res_ready,
    output logic [lsu_pkg::XL:0]        res_rdata,
    output logic                        res_trap,

    output logic                        lsu_valid,
    output logic [MEM_ADDR_R:0]         lsu_addr,
    output logic [lsu_pkg::XL:0]        lsu_wdata,
    output logic                        lsu_load,
    output logic                        lsu_store,
    output logic                        lsu_d_double,
    output logic                        lsu_d_word,
    output logic                        lsu_d_half,
    output logic                        lsu_d_byte,
    output logic                        lsu_sext,
    input  logic                        lsu_ready,
    input  logic                        lsu_trap,
    input  logic [lsu_pkg::XL:0]        lsu_rdata
);

    import lsu_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;  // Waiting for an operation
    localparam logic [1:0] ST_BUSY = 2'd1;  // Access stage working
    localparam logic [1:0] ST_DONE = 2'd2;  // Result waiting for consumer

    logic [1:0]         state;
    logic [SIZE_W-1:0]  size_q;
    logic               busy;

    assign op_ready  = (state == ST_IDLE);
    assign res_valid = (state == ST_DONE);
    assign busy      = (state == ST_BUSY);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (op_valid) state <= ST_BUSY;
                ST_BUSY: if (lsu_ready) state <= ST_DONE;
                ST_DONE: if (res_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operand capture on the operation handshake
    always_ff @(posedge g_clk) begin
        if (op_valid && op_ready) begin
            lsu_addr  <= op_addr;
            lsu_wdata <= op_wdata;
            lsu_load  <= op_load;
            lsu_store <= op_store;
            lsu_sext  <= op_sext;
            size_q    <= op_size;
        end
    end

    // Result capture; only a clean load carries data back
    always_ff @(posedge g_clk) begin
        if (busy && lsu_ready) begin
            res_trap  <= lsu_trap;
            res_rdata <= (lsu_load && !lsu_trap) ? lsu_rdata : '0;
        end
    end

    assign lsu_valid    = busy;
    assign lsu_d_byte   = busy && (size_q == SIZE_BYTE);
    assign lsu_d_half   = busy && (size_q == SIZE_HALF);
    assign lsu_d_word   = busy && (size_q == SIZE_WORD);
    assign lsu_d_double = busy && (size_q == SIZE_DOUBLE);

endmodule

`default_nettype wire

/* core_pipe_exec_lsu.sv */
// Data memory access stage
// Checks alignment, places write data and strobes on the byte lanes, issues
// the req/gnt request and extracts and extends load data from the read word
`timescale 1ns/1ps
`default_nettype none

module core_pipe_exec_lsu #(
    parameter int MEM_ADDR_R = 11
) (
    input  logic                        g_clk,
    input  logic                        g_resetn,

    input  logic                        valid,
    input  logic [MEM_ADDR_R:0]         addr,
    input  logic [lsu_pkg::XL:0]        wdata,
    input  logic                        load,
    input  logic                        store,
    input  logic                        d_double,
    input  logic                        d_word,
    input  logic                        d_half,
    input  logic                        d_byte,
    input  logic                        sext,

    output logic                        ready,
    output logic                        trap_addr,
    output logic [lsu_pkg::XL:0]        rdata,

    output logic                        dmem_req,
    output logic [MEM_ADDR_R:0]         dmem_addr,
    output logic                        dmem_wen,
    output logic [lsu_pkg::MEM_STRB_R:0] dmem_strb,
    output logic [lsu_pkg::MEM_DATA_R:0] dmem_wdata,
    input  logic                        dmem_gnt,
    input  logic [lsu_pkg::MEM_DATA_R:0] dmem_rdata
);

    import lsu_pkg::*;

    logic                   addr_err;
    logic                   req_sent;
    logic [5:0]             lane_shift;
    logic [MEM_STRB_R:0]    size_mask;
    logic [MEM_DATA_R:0]    rdata_shifted;

    // Alignment check per access size; flags are all zero when idle
    assign addr_err = (d_double && |addr[2:0]) ||
                      (d_word   && |addr[1:0]) ||
                      (d_half   &&  addr[0]);

    assign req_sent   = dmem_req && dmem_gnt;
    assign lane_shift = {addr[2:0], 3'b000};  // Byte offset in bits

    // One pulse after the grant or after an alignment error
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ready <= 1'b0;
        end else begin
            ready <= (req_sent || addr_err) && !ready;
        end
    end

    assign trap_addr = addr_err && ready;

    // Request held until granted, never for a misaligned access
    assign dmem_req   = valid && !addr_err && !ready;
    assign dmem_addr  = {addr[MEM_ADDR_R:3], 3'b000};  // Word aligned
    assign dmem_wen   = store;
    assign dmem_wdata = wdata << lane_shift;

    // Lanes covered by the size, moved to the byte offset
    always_comb begin
        if (d_double) begin
            size_mask = 8'hFF;
        end else if (d_word) begin
            size_mask = 8'h0F;
        end else if (d_half) begin
            size_mask = 8'h03;
        end else if (d_byte) begin
            size_mask = 8'h01;
        end else begin
            size_mask = 8'h00;  // Idle, no lanes
        end
    end

    assign dmem_strb = size_mask << addr[2:0];

    // Load path: addressed bytes down to bit 0, then extend
    assign rdata_shifted = dmem_rdata >> lane_shift;

    always_comb begin
        if (d_byte) begin
            rdata = {{(XL - 7){sext && rdata_shifted[7]}}, rdata_shifted[7:0]};
        end else if (d_half) begin
            rdata = {{(XL - 15){sext && rdata_shifted[15]}}, rdata_shifted[15:0]};
        end else if (d_word) begin
            rdata = {{(XL - 31){sext && rdata_shifted[31]}}, rdata_shifted[31:0]};
        end else begin
            rdata = rdata_shifted;  // Double, offset is zero
        end
    end

endmodule

`default_nettype wire

/* dmem_ram.sv */
// Byte-strobed data memory
// Grants a held request after WAIT_CYCLES cycles, writes strobed bytes on a
// granted store and returns the read word one cycle after a granted load
`timescale 1ns/1ps
`default_nettype none

module dmem_ram #(
    parameter int MEM_ADDR_R  = 11,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                         g_clk,
    input  logic                         g_resetn,

    input  logic                         dmem_req,
    input  logic [MEM_ADDR_R:0]          dmem_addr,
    input  logic                         dmem_wen,
    input  logic [lsu_pkg::MEM_STRB_R:0] dmem_strb,
    input  logic [lsu_pkg::MEM_DATA_R:0] dmem_wdata,
    output logic                         dmem_gnt,
    output logic [lsu_pkg::MEM_DATA_R:0] dmem_rdata
);

    import lsu_pkg::*;

    localparam int         DEPTH  = 2 ** (MEM_ADDR_R - 2);
    localparam logic [2:0] WAIT_N = 3'(WAIT_CYCLES);

    logic [MEM_DATA_R:0]   mem [DEPTH];
    logic [2:0]            wait_cnt;
    logic [MEM_ADDR_R-3:0] word_idx;

    assign word_idx = dmem_addr[MEM_ADDR_R:3];
    assign dmem_gnt = dmem_req && (wait_cnt == WAIT_N);

    // Cycles the current request has been held
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wait_cnt <= 3'd0;
        end else if (dmem_gnt) begin
            wait_cnt <= 3'd0;
        end else if (dmem_req) begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (dmem_gnt && dmem_wen) begin
            for (int i = 0; i <= MEM_STRB_R; i++) begin
                if (dmem_strb[i]) begin
                    mem[word_idx][i*8 +: 8] <= dmem_wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (dmem_gnt && !dmem_wen) begin
            dmem_rdata <= mem[word_idx];  // Seen the cycle after grant
        end
    end

endmodule

`default_nettype wire

/* lsu_subsys_top.sv */
// Load/store subsystem top level
// Operation buffer, access stage and data memory wired together
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys_top #(
    parameter int MEM_ADDR_R  = 11,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                        g_clk,
    input  logic                        g_resetn,

    input  logic                        op_valid,
    output logic                        op_ready,
    input  logic [MEM_ADDR_R:0]         op_addr,
    input  logic [lsu_pkg::XL:0]        op_wdata,
    input  logic                        op_load,
    input  logic                        op_store,
    input  logic [lsu_pkg::SIZE_W-1:0]  op_size,
    input  logic                        op_sext,

    output logic                        res_valid,
    input  logic                        res_ready,
    output logic [lsu_pkg::XL:0]        res_rdata,
    output logic                        res_trap
);

    import lsu_pkg::*;

    // Buffer to access stage
    logic                lsu_valid;
    logic [MEM_ADDR_R:0] lsu_addr;
    logic [XL:0]         lsu_wdata;
    logic                lsu_load;
    logic                lsu_store;
    logic                lsu_d_double;
    logic                lsu_d_word;
    logic                lsu_d_half;
    logic                lsu_d_byte;
    logic                lsu_sext;
    logic                lsu_ready;
    logic                lsu_trap;
    logic [XL:0]         lsu_rdata;

    // Access stage to memory
    logic                dmem_req;
    logic [MEM_ADDR_R:0] dmem_addr;
    logic                dmem_wen;
    logic [MEM_STRB_R:0] dmem_strb;
    logic [MEM_DATA_R:0] dmem_wdata;
    logic                dmem_gnt;
    logic [MEM_DATA_R:0] dmem_rdata;

    mem_op_buffer #(
        .MEM_ADDR_R (MEM_ADDR_R)
    ) buffer_i (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .op_addr      (op_addr),
        .op_wdata     (op_wdata),
        .op_load      (op_load),
        .op_store     (op_store),
        .op_size      (op_size),
        .op_sext      (op_sext),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res_rdata    (res_rdata),
        .res_trap     (res_trap),
        .lsu_valid    (lsu_valid),
        .lsu_addr     (lsu_addr),
        .lsu_wdata    (lsu_wdata),
        .lsu_load     (lsu_load),
        .lsu_store    (lsu_store),
        .lsu_d_double (lsu_d_double),
        .lsu_d_word   (lsu_d_word),
        .lsu_d_half   (lsu_d_half),
        .lsu_d_byte   (lsu_d_byte),
        .lsu_sext     (lsu_sext),
        .lsu_ready    (lsu_ready),
        .lsu_trap     (lsu_trap),
        .lsu_rdata    (lsu_rdata)
    );

    core_pipe_exec_lsu #(
        .MEM_ADDR_R (MEM_ADDR_R)
    ) lsu_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .valid      (lsu_valid),
        .addr       (lsu_addr),
        .wdata      (lsu_wdata),
        .load       (lsu_load),
        .store      (lsu_store),
        .d_double   (lsu_d_double),
        .d_word     (lsu_d_word),
        .d_half     (lsu_d_half),
        .d_byte     (lsu_d_byte),
        .sext       (lsu_sext),
        .ready      (lsu_ready),
        .trap_addr  (lsu_trap),
        .rdata      (lsu_rdata),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_strb  (dmem_strb),
        .dmem_wdata (dmem_wdata),
        .dmem_gnt   (dmem_gnt),
        .dmem_rdata (dmem_rdata)
    );

    dmem_ram #(
        .MEM_ADDR_R  (MEM_ADDR_R),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) ram_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_strb  (dmem_strb),
        .dmem_wdata (dmem_wdata),
        .dmem_gnt   (dmem_gnt),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

/* tb_lsu_subsys.sv */
// Testbench for the load/store subsystem
// Drives operations through the buffer, tracks memory in a shadow byte array
// and compares every result against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_subsys;

    import lsu_pkg::*;

    localparam int MEM_ADDR_R = 11;
    localparam int ADDR_W     = MEM_ADDR_R + 1;
    localparam int TIMEOUT    = 200;  // Cycles per wait

    logic                g_clk;
    logic                g_resetn;
    logic                op_valid;
    logic                op_ready;
    logic [ADDR_W-1:0]   op_addr;
    logic [XL:0]         op_wdata;
    logic                op_load;
    logic                op_store;
    logic [SIZE_W-1:0]   op_size;
    logic                op_sext;
    logic                res_valid;
    logic                res_ready;
    logic [XL:0]         res_rdata;
    logic                res_trap;

    logic [7:0]          shadow [0:(2**ADDR_W)-1];
    logic [XL+1:0]       exp_q [$];  // {trap, data} per issued operation
    logic [XL+1:0]       exp_entry;
    int                  err_count = 0;
    int                  check_count = 0;
    logic                timed_out = 1'b0;

    lsu_subsys_top #(
        .MEM_ADDR_R  (MEM_ADDR_R),
        .WAIT_CYCLES (2)
    ) dut_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_addr   (op_addr),
        .op_wdata  (op_wdata),
        .op_load   (op_load),
        .op_store  (op_store),
        .op_size   (op_size),
        .op_sext   (op_sext),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rdata (res_rdata),
        .res_trap  (res_trap)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    task automatic check_value(input string what, input logic [XL:0] got,
                               input logic [XL:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Expected {trap, data}; aligned stores also update the shadow
    function automatic logic [XL+1:0] ref_result(input logic [ADDR_W-1:0] addr,
            input logic [XL:0] wdata, input logic store, input logic [SIZE_W-1:0] size,
            input logic sext);
        int          nbytes;
        logic [XL:0] value;
        nbytes = 1 << size;
        value  = '0;
        if ((addr & (nbytes - 1)) != 0) begin
            ref_result = {1'b1, {(XL+1){1'b0}}};  // Misaligned, memory untouched
        end else if (store) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[addr + i] = wdata[i*8 +: 8];
            end
            ref_result = '0;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                value[i*8 +: 8] = shadow[addr + i];  // Little endian
            end
            if (sext && value[nbytes*8 - 1]) begin
                for (int i = nbytes * 8; i <= XL; i++) begin
                    value[i] = 1'b1;
                end
            end
            ref_result = {1'b0, value};
        end
    endfunction

    function automatic logic [XL:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr ^ 12'hA5C, 4'h9, addr ^ 12'h3F1, 4'h6, ~addr, 4'hE, addr, 4'h1};
    endfunction

    task automatic drive_op(input logic [ADDR_W-1:0] addr, input logic [XL:0] wdata,
            input logic load, input logic [SIZE_W-1:0] size, input logic sext);
        op_valid <= 1'b1;
        op_addr  <= addr;
        op_wdata <= wdata;
        op_load  <= load;
        op_store <= !load;
        op_size  <= size;
        op_sext  <= sext;
    endtask

    task automatic wait_accept();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen && !timed_out; n++) begin
            @(posedge g_clk);
            seen = op_ready;
        end
        op_valid <= 1'b0;
        if (!seen && !timed_out) begin
            $display("Timed out after %0d cycles waiting for op_ready", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_result();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen && !timed_out; n++) begin
            @(posedge g_clk);
            seen = res_valid;
        end
        if (!seen && !timed_out) begin
            $display("Timed out after %0d cycles waiting for res_valid", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // Holds res_ready low for stall cycles, then takes the result
    task automatic take_result(input int stall);
        logic [XL:0] held_data;
        logic        held_trap;
        wait_result();
        if (!timed_out) begin
            held_data = res_rdata;
            held_trap = res_trap;
            repeat (stall) begin
                @(posedge g_clk);
                check_value("res_valid while stalled", 64'(res_valid), 64'd1);
                check_value("res_rdata while stalled", res_rdata, held_data);
                check_value("res_trap while stalled", 64'(res_trap), 64'(held_trap));
                check_value("op_ready while stalled", 64'(op_ready), 64'd0);
            end
            res_ready <= 1'b1;
            @(posedge g_clk);
            res_ready <= 1'b0;
        end
    endtask

    task automatic do_access(input logic [ADDR_W-1:0] addr, input logic [XL:0] wdata,
            input logic load, input logic [SIZE_W-1:0] size, input logic sext, input int stall);
        if (!timed_out) begin
            exp_q.push_back(ref_result(addr, wdata, !load, size, sext));
            drive_op(addr, wdata, load, size, sext);
            wait_accept();
            take_result(stall);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before && !timed_out) begin
            $display("Test %0d (%s) passed", num, name);
        end else begin
            $display("Test %0d (%s) failed with %0d errors", num, name, err_count - errs_before);
        end
    endtask

    // Compares every result half a cycle before the edge that takes it
    always @(negedge g_clk) begin
        if (g_resetn && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result returned at %0t with no operation outstanding", $time);
                err_count++;
            end else begin
                exp_entry = exp_q.pop_front();
                check_value("res_rdata", res_rdata, exp_entry[XL:0]);
                check_value("res_trap", 64'(res_trap), 64'(exp_entry[XL+1]));
            end
        end
    end

    initial begin
        int          errs;
        int          stall;
        logic        ld;
        logic [XL:0] rnd;
        void'($urandom(16971));
        g_resetn  = 1'b0;
        op_valid  = 1'b0;
        op_addr   = '0;
        op_wdata  = '0;
        op_load   = 1'b0;
        op_store  = 1'b0;
        op_size   = SIZE_BYTE;
        op_sext   = 1'b0;
        res_ready = 1'b0;
        repeat (4) @(posedge g_clk);
        check_value("op_ready in reset", 64'(op_ready), 64'd1);
        check_value("res_valid in reset", 64'(res_valid), 64'd0);
        g_resetn <= 1'b1;

        // Known contents for the low 256 bytes
        for (int a = 0; a < 256; a += 8) begin
            do_access(ADDR_W'(a), fill_word(ADDR_W'(a)), 1'b0, SIZE_DOUBLE, 1'b0, 0);
        end

        errs = err_count;
        do_access(12'h080, 64'h81F2_63D4_C5B6_2798, 1'b0, SIZE_DOUBLE, 1'b0, 0);
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                for (int sx = 0; sx < 2; sx++) begin
                    do_access(ADDR_W'(12'h080 + off), '0, 1'b1, SIZE_W'(sz), 1'(sx), 0);
                end
            end
        end
        do_access(12'h080, '0, 1'b1, SIZE_DOUBLE, 1'b0, 0);
        report_test(1, "load extension", errs);

        errs = err_count;
        do_access(12'h088, 64'h0123_4567_89AB_CDEF, 1'b0, SIZE_DOUBLE, 1'b0, 0);
        for (int sz = 0; sz < 2; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                rnd = {$urandom(), $urandom()};
                do_access(ADDR_W'(12'h088 + off), rnd, 1'b0, SIZE_W'(sz), 1'b0, 0);
                do_access(12'h088, '0, 1'b1, SIZE_DOUBLE, 1'b0, 0);  // Neighbours intact
            end
        end
        report_test(2, "partial stores", errs);

        errs = err_count;
        for (int sz = 1; sz < 4; sz++) begin
            for (int off = 1; off < 8; off++) begin
                if ((off % (1 << sz)) != 0) begin
                    rnd = {$urandom(), $urandom()};
                    do_access(ADDR_W'(12'h090 + off), rnd, 1'b0, SIZE_W'(sz), 1'b0, 0);
                    do_access(ADDR_W'(12'h090 + off), '0, 1'b1, SIZE_W'(sz), 1'b1, 0);
                end
            end
        end
        do_access(12'h090, '0, 1'b1, SIZE_DOUBLE, 1'b0, 0);
        do_access(12'h098, '0, 1'b1, SIZE_DOUBLE, 1'b0, 0);
        report_test(3, "misaligned traps", errs);

        errs = err_count;
        for (int r = 0; r < 4 && !timed_out; r++) begin
            stall = int'($urandom_range(2, 10));
            exp_q.push_back(ref_result(ADDR_W'(12'h080 + 4 * r), '0, 1'b0, SIZE_WORD, 1'b1));
            drive_op(ADDR_W'(12'h080 + 4 * r), '0, 1'b1, SIZE_WORD, 1'b1);
            wait_accept();
            // Next operation waits on the port while the result is held
            exp_q.push_back(ref_result(12'h088, '0, 1'b0, SIZE_DOUBLE, 1'b0));
            drive_op(12'h088, '0, 1'b1, SIZE_DOUBLE, 1'b0);
            take_result(stall);
            wait_accept();
            take_result(0);
        end
        report_test(4, "back-pressure", errs);

        errs = err_count;
        for (int n = 0; n < 200; n++) begin
            rnd = {$urandom(), $urandom()};
            ld  = 1'($urandom_range(0, 1));
            do_access(ADDR_W'($urandom_range(0, 255)), rnd, ld, SIZE_W'($urandom_range(0, 3)),
                      1'($urandom_range(0, 1)), int'($urandom_range(0, 3)));
        end
        report_test(5, "random operations", errs);

        check_value("results left outstanding", 64'(exp_q.size()), 64'd0);
        $display("Checks run: %0d, errors: %0d, timeout: %0d", check_count, err_count, timed_out);
        if (err_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_subsys_top.f */
lsu_pkg.sv
mem_op_buffer.sv
core_pipe_exec_lsu.sv
dmem_ram.sv
lsu_subsys_top.sv
tb_lsu_subsys.sv
